/* project.f */
+incdir+.
snd_pkg.sv
snd_bus_if.sv
snd_cpu.sv
snd_decode.sv
snd_tone.sv
snd_top.sv
snd_assertions.sv
tb_snd.sv

/* run.sh */
#!/bin/sh
# build and run the sound board testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -Wno-fatal -f project.f \
    --top-module tb_snd -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_snd > sim.log 2>&1 ; \
grep -q "Simulation PASSED" sim.log \
    && echo "run ok" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

/* tb_snd.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_snd;
    localparam int WAIT_LIMIT = 20000;  // clocks for long waits
    localparam int FLIP_LIMIT = 2000;   // one half wave at most

    logic               clk;
    logic               rst_n;
    logic               cen_fm;
    logic               cen_fm2;
    logic [7:0]         latch;
    logic [14:0]        rom_addr;
    logic               rom_cs;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic               sample;

    logic [7:0] rom_img [0:32767];
    logic [1:0] cen_cnt;
    logic       armed;              // delay picked for this rom cycle
    int         wait_left;
    integer     seed;
    int         pc_asm;
    int         loop_pc;            // address of the idle jump
    int         errors;
    int         checks;

    snd_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen_fm   (cen_fm),
        .cen_fm2  (cen_fm2),
        .latch    (latch),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .left     (left),
        .right    (right),
        .sample   (sample)
    );

    bind snd_top snd_assertions u_chk (
        .clk(clk), .rst_n(rst_n), .cen_fm2(cen_fm2), .rom_addr(rom_addr),
        .rom_cs(rom_cs), .rom_ok(rom_ok), .left(left), .right(right), .sample(sample)
    );

    always #20 clk = ~clk;

    // cpu step every other clock, sample every fourth
    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen_fm  <= cen_cnt[0];
        cen_fm2 <= (cen_cnt == 2'd3);
    end

    // rom with a random 0..5 clock answer delay
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok <= 1'b0;
            armed  <= 1'b0;
        end else if (!armed) begin
            armed     <= 1'b1;
            wait_left <= int'({$random(seed)} % 6);
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
        end else begin
            rom_ok   <= 1'b1;
            rom_data <= rom_img[rom_addr];
        end
    end

    task automatic put_byte(input logic [7:0] b);
        rom_img[pc_asm] = b;
        pc_asm++;
    endtask

    task automatic asm_imm(input snd_pkg::snd_opcode_e op, input logic [7:0] n);
        put_byte(op);
        put_byte(n);
    endtask

    task automatic asm_addr(input snd_pkg::snd_opcode_e op, input logic [15:0] nn);
        put_byte(op);
        put_byte(nn[7:0]);      // little endian like z80
        put_byte(nn[15:8]);
    endtask

    task automatic load_program();
        for (int i = 0; i < 32768; i++)
            rom_img[i] = 8'(i ^ (i >> 8));
        pc_asm = 0;
        asm_imm(snd_pkg::INP, 8'hC0);           // a = latch
        asm_addr(snd_pkg::STM, 16'hF800);
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::CH0_VOL));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_addr(snd_pkg::LDM, 16'hF800);       // ram round trip, a was overwritten
        asm_imm(snd_pkg::OUTP, 8'h01);
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::CH0_PERIOD));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::LDI, 8'h03);
        asm_imm(snd_pkg::OUTP, 8'h01);
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::CH1_PERIOD));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::INP, 8'h80);           // pcm port, open bus
        asm_imm(snd_pkg::OUTP, 8'h01);
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::TIMER_CTRL));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::LDI, 8'h01);
        asm_imm(snd_pkg::OUTP, 8'h01);          // irq on ahead of the count
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::TIMER_LOAD));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::LDI, 8'h0A);
        asm_imm(snd_pkg::OUTP, 8'h01);
        loop_pc = pc_asm;
        asm_addr(snd_pkg::JMP, 16'(loop_pc));   // main loop, lands on itself
        // isr at the fixed vector
        pc_asm = 16'h0038;
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::CH1_VOL));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::LDI, 8'h20);
        asm_imm(snd_pkg::OUTP, 8'h01);
        asm_imm(snd_pkg::LDI, 8'(snd_pkg::TIMER_CTRL));
        asm_imm(snd_pkg::OUTP, 8'h00);
        asm_imm(snd_pkg::LDI, 8'h01);
        asm_imm(snd_pkg::OUTP, 8'h01);          // ack flag
        put_byte(snd_pkg::RETI);
    endtask

    task automatic check_val(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic int magnitude(input logic signed [15:0] v);
        return v[15] ? -int'(v) : int'(v);
    endfunction

    // counts sample pulses until the channel sign flips
    task automatic wait_flip(input bit ch, output int pulses, output bit ok);
        bit s0;
        s0     = ch ? right[15] : left[15];
        pulses = 0;
        ok     = 1'b0;
        for (int t = 0; t < FLIP_LIMIT && !ok; t++) begin
            @(negedge clk);
            if (sample) begin
                pulses++;
                if ((ch ? right[15] : left[15]) != s0)
                    ok = 1'b1;
            end
        end
        if (!ok) begin
            errors++;
            $display("timeout: channel %0d never changed sign", ch);
        end
    endtask

    initial begin
        int  n;
        bit  ok;
        bit  hit;
        clk     = 1'b0;
        rst_n   = 1'b0;
        cen_cnt = 2'd0;
        cen_fm  = 1'b0;
        cen_fm2 = 1'b0;
        latch   = 8'h00;
        rom_ok  = 1'b0;
        rom_data = 8'h00;
        armed   = 1'b0;
        wait_left = 0;
        seed    = 66;
        errors  = 0;
        checks  = 0;
        load_program();

        @(posedge clk);
        latch <= 8'h1B;             // command from the main board
        repeat (15) @(posedge clk);
        rst_n <= 1'b1;

        // isr done once channel 1 gets a volume
        hit = 1'b0;
        for (int t = 0; t < WAIT_LIMIT && !hit; t++) begin
            @(negedge clk);
            hit = (right != 16'sd0);
        end
        if (!hit) begin
            errors++;
            $display("timeout: timer interrupt never set channel 1 volume");
        end else begin
            // channel 0, latch volume at period 3
            wait_flip(1'b0, n, ok);
            for (int k = 0; k < 4 && ok; k++) begin
                wait_flip(1'b0, n, ok);
                if (ok) begin
                    check_val("ch0_run", 3, n);
                    check_val("ch0_amp", 'h1B * 64, magnitude(left));
                end
            end
            // channel 1, period from the 0xff read
            wait_flip(1'b1, n, ok);
            for (int k = 0; k < 2 && ok; k++) begin
                wait_flip(1'b1, n, ok);
                if (ok) begin
                    check_val("ch1_run", 255, n);
                    check_val("ch1_amp", 'h20 * 64, magnitude(right));
                end
            end
            // back in the main loop after reti
            hit = 1'b0;
            for (int t = 0; t < WAIT_LIMIT && !hit; t++) begin
                @(negedge clk);
                hit = rom_cs && rom_addr >= loop_pc && rom_addr <= loop_pc + 2;
            end
            checks++;
            if (!hit) begin
                errors++;
                $display("timeout: no fetch from the main loop after the interrupt");
            end
        end

        $display("checks %0d errors %0d assertion failures %0d",
                 checks, errors, uut.u_chk.fails);
        if (errors == 0 && uut.u_chk.fails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end
endmodule

`default_nettype wire

/* snd_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

// bound into snd_top, watches the board side ports
module snd_assertions (
    input wire        clk,
    input wire        rst_n,
    input wire        cen_fm2,
    input wire [14:0] rom_addr,
    input wire        rom_cs,
    input wire        rom_ok,
    input wire [15:0] left,
    input wire [15:0] right,
    input wire        sample
);
    logic seen_cs;      // any rom cycle since reset
    int   fails = 0;    // failed assertions so far

    always_ff @(posedge clk) begin
        if (!rst_n)
            seen_cs <= 1'b0;
        else if (rom_cs)
            seen_cs <= 1'b1;
    end

    // outputs quiet straight out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !rom_cs && !sample && left == 16'd0 && right == 16'd0)
        else begin
            fails++;
            $error("outputs not idle after reset");
        end

    // boot fetch comes from address 0
    boot_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !seen_cs |-> rom_addr == 15'd0)
        else begin
            fails++;
            $error("first rom cycle not at address 0");
        end

    // back-pressure holds the rom address
    rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else begin
            fails++;
            $error("rom address moved while waiting on rom_ok");
        end

    // one sample pulse per cen_fm2
    sample_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> sample == $past(cen_fm2))
        else begin
            fails++;
            $error("sample strobe out of step with cen_fm2");
        end

    // outputs only move on sample clocks
    audio_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(cen_fm2) |-> $stable(left) && $stable(right))
        else begin
            fails++;
            $error("audio changed between sample clocks");
        end
endmodule

`default_nettype wire

/* snd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module snd_top (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                cen_fm,      // cpu step
    input  wire                cen_fm2,     // sample rate
    input  wire  [7:0]         latch,       // from the main board
    output logic [14:0]        rom_addr,
    output logic               rom_cs,
    input  wire  [7:0]         rom_data,
    input  wire                rom_ok,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);
    logic       fm_we;
    logic       fm_a0;
    logic [7:0] fm_wdata;
    logic [7:0] fm_rdata;
    logic       irq_n;

    snd_bus_if bus ();

    snd_cpu u_cpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen_fm   (cen_fm),
        .bus      (bus.cpu),
        .irq_n    (irq_n)
    );

    snd_decode u_dec (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.dec),
        .latch    (latch),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .fm_we    (fm_we),
        .fm_a0    (fm_a0),
        .fm_wdata (fm_wdata),
        .fm_rdata (fm_rdata)
    );

    snd_tone u_tone (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen_fm2  (cen_fm2),
        .fm_we    (fm_we),
        .fm_a0    (fm_a0),
        .fm_wdata (fm_wdata),
        .fm_rdata (fm_rdata),
        .irq_n    (irq_n),
        .left     (left),
        .right    (right),
        .sample   (sample)
    );
endmodule

`default_nettype wire

/* snd_tone.sv */
`timescale 1ns/100ps
`default_nettype none
`include "snd_config.svh"

module snd_tone (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                cen_fm2,
    input  wire                fm_we,
    input  wire                fm_a0,
    input  wire  [7:0]         fm_wdata,
    output logic [7:0]         fm_rdata,
    output logic               irq_n,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);
    snd_pkg::snd_tone_reg_e idx;        // latched by an a0=0 write
    logic [7:0]         period [2];
    logic [7:0]         vol [2];
    logic [7:0]         cnt [2];        // samples into the half wave
    logic [7:0]         last [2];       // terminal count
    logic [1:0]         phase;
    logic signed [15:0] amp [2];
    logic [7:0]         timer;
    logic               irq_en;
    logic               flag;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            amp[i]  = 16'(vol[i]) << `SND_AMP_SHIFT;
            last[i] = (period[i] == 8'd0) ? 8'd0 : period[i] - 8'd1;  // 0 acts as 1
        end
    end

    assign fm_rdata = {7'd0, flag};     // both ports read status
    assign irq_n    = !(flag && irq_en);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx    <= snd_pkg::CH0_PERIOD;
            phase  <= 2'b00;
            timer  <= 8'd0;
            irq_en <= 1'b0;
            flag   <= 1'b0;
            left   <= 16'sd0;
            right  <= 16'sd0;
            sample <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                period[i] <= 8'd0;
                vol[i]    <= 8'd0;
                cnt[i]    <= 8'd0;
            end
        end else begin
            sample <= cen_fm2;          // outputs move with this strobe
            if (cen_fm2) begin
                for (int i = 0; i < 2; i++) begin
                    if (cnt[i] >= last[i]) begin
                        cnt[i]   <= 8'd0;
                        phase[i] <= ~phase[i];
                    end else begin
                        cnt[i] <= cnt[i] + 8'd1;
                    end
                end
                left  <= phase[0] ? -amp[0] : amp[0];
                right <= phase[1] ? -amp[1] : amp[1];
                if (timer != 8'd0) begin      // one shot
                    timer <= timer - 8'd1;
                    if (timer == 8'd1)
                        flag <= 1'b1;
                end
            end
            // register writes after the sample step, so a clear wins
            if (fm_we) begin
                if (!fm_a0) begin
                    idx <= snd_pkg::snd_tone_reg_e'(fm_wdata[2:0]);
                end else begin
                    case (idx)
                        snd_pkg::CH0_PERIOD: period[0] <= fm_wdata;
                        snd_pkg::CH0_VOL:    vol[0]    <= fm_wdata;
                        snd_pkg::CH1_PERIOD: period[1] <= fm_wdata;
                        snd_pkg::CH1_VOL:    vol[1]    <= fm_wdata;
                        snd_pkg::TIMER_LOAD: timer     <= fm_wdata;
                        snd_pkg::TIMER_CTRL: begin
                            irq_en <= fm_wdata[0];
                            flag   <= 1'b0;     // ack
                        end
                        default: idx <= idx;    // unused index
                    endcase
                end
            end
        end
    end
endmodule

`default_nettype wire

/* snd_decode.sv */
`timescale 1ns/100ps
`default_nettype none
`include "snd_config.svh"

module snd_decode (
    input  wire                      clk,
    input  wire                      rst_n,
    snd_bus_if.dec                   bus,
    input  wire  [7:0]               latch,
    output logic [`SND_ROM_AW-1:0]   rom_addr,
    output logic                     rom_cs,
    input  wire  [7:0]               rom_data,
    input  wire                      rom_ok,
    output logic                     fm_we,
    output logic                     fm_a0,
    output logic [7:0]               fm_wdata,
    input  wire  [7:0]               fm_rdata
);
    logic [7:0]             ram [0:(1<<`SND_RAM_AW)-1];
    logic [`SND_RAM_AW-1:0] ram_idx;
    logic [15:0]            mem_page;   // 2 KB granule of the address
    logic [7:0]             io_grp;     // A[7:6] of the port
    logic                   acc_now;    // strobe present this clock
    logic                   acc_q;
    logic                   ram_cs, fm_cs, latch_cs;
    logic                   rom_ok_q;
    logic                   rom_good;
    logic                   first;      // access seen, not yet acked

    assign rom_addr = bus.addr[`SND_ROM_AW-1:0];
    assign ram_idx  = bus.addr[`SND_RAM_AW-1:0];
    assign mem_page = bus.addr & 16'hF800;
    assign io_grp   = bus.addr[7:0] & 8'hC0;
    assign acc_now  = bus.mreq | bus.iorq;
    assign rom_good = rom_cs & rom_ok & rom_ok_q;   // ok held two clocks
    assign first    = acc_now & ~bus.ready;

    // chip selects one clock behind the address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= 1'b0;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            latch_cs  <= 1'b0;
            fm_cs     <= 1'b0;
            rom_ok_q  <= 1'b0;
            bus.ready <= 1'b0;
            fm_we     <= 1'b0;
        end else begin
            acc_q    <= acc_now;
            rom_cs   <= bus.mreq & ~bus.addr[`SND_ROM_AW];
            ram_cs   <= bus.mreq & (mem_page == `SND_RAM_BASE);
            latch_cs <= (bus.mreq & (mem_page == `SND_LATCH_MEM))
                      | (bus.iorq & (io_grp == `SND_LATCH_PORT));
            fm_cs    <= bus.iorq & (io_grp == `SND_FM_PORT);
            rom_ok_q <= rom_cs & rom_ok;
            if (rom_cs)
                bus.ready <= acc_now & rom_good;
            else
                bus.ready <= acc_now & acc_q;   // everything else next clock
            fm_we <= fm_cs & bus.wr & first;     // one clock per access
        end
    end

    // read mux and ram, payload only
    always_ff @(posedge clk) begin
        if (bus.rd && !bus.ready) begin          // frozen once acked
            if (rom_cs)
                bus.rdata <= rom_data;
            else if (ram_cs)
                bus.rdata <= ram[ram_idx];
            else if (fm_cs)
                bus.rdata <= fm_rdata;           // status byte
            else if (latch_cs)
                bus.rdata <= latch;
            else
                bus.rdata <= 8'hFF;              // open bus, pcm port included
        end
        if (ram_cs && bus.wr && first)
            ram[ram_idx] <= bus.wdata;
        fm_a0    <= bus.addr[0];
        fm_wdata <= bus.wdata;
    end
endmodule

`default_nettype wire

/* snd_cpu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "snd_config.svh"

module snd_cpu (
    input wire     clk,
    input wire     rst_n,
    input wire     cen_fm,
    snd_bus_if.cpu bus,
    input wire     irq_n
);
    snd_pkg::snd_cpu_state_e state;
    snd_pkg::snd_opcode_e    opcode;
    snd_pkg::snd_opcode_e    fetched;   // opcode byte on the bus
    logic [15:0] pc;
    logic [15:0] shadow_pc;             // single level, no stack
    logic [7:0]  acc;
    logic [7:0]  op_lo;
    logic [7:0]  op_hi;
    logic        in_isr;
    logic        busy;                  // strobes out, waiting ready
    logic        take_irq;
    logic        wide;                  // two operand bytes
    logic        start;
    logic [15:0] nxt_addr;
    logic        nxt_io;
    logic        nxt_wr;

    assign fetched  = snd_pkg::snd_opcode_e'(bus.rdata);
    assign take_irq = !irq_n && !in_isr;
    assign wide     = opcode inside {snd_pkg::LDM, snd_pkg::STM, snd_pkg::JMP};

    // which access the current state wants
    always_comb begin
        start    = 1'b0;
        nxt_addr = pc;
        nxt_io   = 1'b0;
        nxt_wr   = 1'b0;
        case (state)
            snd_pkg::FETCH:      start = !take_irq;  // irq wins over the fetch
            snd_pkg::OPERAND_LO: start = 1'b1;
            snd_pkg::OPERAND_HI: start = 1'b1;
            snd_pkg::EXECUTE: begin
                case (opcode)
                    snd_pkg::LDM, snd_pkg::STM: begin
                        start    = 1'b1;
                        nxt_addr = {op_hi, op_lo};
                        nxt_wr   = (opcode == snd_pkg::STM);
                    end
                    snd_pkg::INP, snd_pkg::OUTP: begin
                        start    = 1'b1;
                        nxt_addr = {acc, op_lo};     // a on the upper byte, as z80
                        nxt_io   = 1'b1;
                        nxt_wr   = (opcode == snd_pkg::OUTP);
                    end
                    default: start = 1'b0;           // internal ops
                endcase
            end
            default: start = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= snd_pkg::FETCH;
            opcode   <= snd_pkg::NOP;
            pc       <= 16'h0000;
            acc      <= 8'h00;
            in_isr   <= 1'b0;
            busy     <= 1'b0;
            bus.addr <= 16'h0000;
            bus.mreq <= 1'b0;
            bus.iorq <= 1'b0;
            bus.rd   <= 1'b0;
            bus.wr   <= 1'b0;
        end else if (cen_fm) begin
            if (busy) begin
                if (bus.ready) begin
                    // access done, strobes drop for at least one cen
                    busy     <= 1'b0;
                    bus.mreq <= 1'b0;
                    bus.iorq <= 1'b0;
                    bus.rd   <= 1'b0;
                    bus.wr   <= 1'b0;
                    case (state)
                        snd_pkg::FETCH: begin
                            opcode <= fetched;
                            pc     <= pc + 16'd1;
                            case (fetched)
                                snd_pkg::NOP, snd_pkg::RETI: state <= snd_pkg::EXECUTE;
                                snd_pkg::LDI, snd_pkg::LDM, snd_pkg::STM, snd_pkg::INP,
                                snd_pkg::OUTP, snd_pkg::JMP: state <= snd_pkg::OPERAND_LO;
                                default: state <= snd_pkg::EXECUTE;  // unknown runs as nop
                            endcase
                        end
                        snd_pkg::OPERAND_LO: begin
                            op_lo <= bus.rdata;
                            pc    <= pc + 16'd1;
                            state <= wide ? snd_pkg::OPERAND_HI : snd_pkg::EXECUTE;
                        end
                        snd_pkg::OPERAND_HI: begin
                            op_hi <= bus.rdata;
                            pc    <= pc + 16'd1;
                            state <= snd_pkg::EXECUTE;
                        end
                        default: begin
                            if (opcode == snd_pkg::LDM || opcode == snd_pkg::INP)
                                acc <= bus.rdata;
                            state <= snd_pkg::FETCH;
                        end
                    endcase
                end
            end else if (start) begin
                bus.addr  <= nxt_addr;
                bus.wdata <= acc;
                bus.mreq  <= !nxt_io;
                bus.iorq  <= nxt_io;
                bus.rd    <= !nxt_wr;
                bus.wr    <= nxt_wr;
                busy      <= 1'b1;
                if (state == snd_pkg::EXECUTE)
                    state <= snd_pkg::MEMWAIT;
            end else begin
                case (state)
                    snd_pkg::FETCH: state <= snd_pkg::IRQ_ENTER;  // only reached on take_irq
                    snd_pkg::IRQ_ENTER: begin
                        shadow_pc <= pc;
                        pc        <= `SND_IRQ_VEC;
                        in_isr    <= 1'b1;   // masks further entries until reti
                        state     <= snd_pkg::FETCH;
                    end
                    snd_pkg::EXECUTE: begin
                        case (opcode)
                            snd_pkg::LDI: acc <= op_lo;
                            snd_pkg::JMP: pc <= {op_hi, op_lo};
                            snd_pkg::RETI: begin
                                pc     <= shadow_pc;
                                in_isr <= 1'b0;
                            end
                            default: acc <= acc;   // nop
                        endcase
                        state <= snd_pkg::FETCH;
                    end
                    default: state <= snd_pkg::FETCH;
                endcase
            end
        end
    end
endmodule

`default_nettype wire

/* snd_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// sound cpu bus, z80 shape with active high strobes
interface snd_bus_if;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;     // registered by the decoder
    logic        mreq;      // memory cycle
    logic        iorq;      // port cycle, A[7:0] only
    logic        rd;
    logic        wr;
    logic        ready;     // level, high until strobes drop

    modport cpu (
        output addr, wdata, mreq, iorq, rd, wr,
        input  rdata, ready
    );

    modport dec (
        input  addr, wdata, mreq, iorq, rd, wr,
        output rdata, ready
    );
endinterface

`default_nettype wire

/* snd_pkg.sv */
`default_nettype none

package snd_pkg;

    // z80-like byte codes so a dump reads familiar
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        LDI  = 8'h3E,   // a <- n
        LDM  = 8'h3A,   // a <- (nn)
        STM  = 8'h32,   // (nn) <- a
        INP  = 8'hDB,   // a <- in (n)
        OUTP = 8'hD3,   // out (n) <- a
        JMP  = 8'hC3,   // pc <- nn
        RETI = 8'h4D    // second byte of the z80 reti pair
    } snd_opcode_e;

    typedef enum logic [2:0] {
        FETCH,
        OPERAND_LO,
        OPERAND_HI,
        EXECUTE,
        MEMWAIT,        // data access in flight
        IRQ_ENTER
    } snd_cpu_state_e;

    // written through the fm address port
    typedef enum logic [2:0] {
        CH0_PERIOD = 3'd0,
        CH0_VOL    = 3'd1,
        CH1_PERIOD = 3'd2,
        CH1_VOL    = 3'd3,
        TIMER_LOAD = 3'd4,  // samples until the flag sets
        TIMER_CTRL = 3'd5   // bit 0 irq enable, write clears flag
    } snd_tone_reg_e;

endpackage

`default_nettype wire

/* snd_config.svh */
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// address widths
`define SND_ROM_AW      15          // 32 KB program rom, A15 low
`define SND_RAM_AW      11          // 2 KB work ram

// memory map, 2 KB granules
`define SND_RAM_BASE    16'hF800
`define SND_LATCH_MEM   16'hE800    // command latch, memory side

// i/o ports, matched on A[7:6]
`define SND_FM_PORT     8'h00       // A[0] picks address or data
`define SND_PCM_PORT    8'h80       // decoded, reads 0xFF
`define SND_LATCH_PORT  8'hC0

// fixed interrupt entry, im1 style
`define SND_IRQ_VEC     16'h0038

// volume to sample scaling
`define SND_AMP_SHIFT   6

`endif
